// ==== hdl/mastermind_pkg.sv ====
package mastermind_pkg;

    localparam int NUM_PEGS = 4;
    localparam int PEG_W = 3;
    localparam int SEG_W = 7;
    localparam int HEX_DIGITS = 6;

    typedef logic [PEG_W-1:0] peg_t;
    typedef logic [1:0] peg_index_t;
    typedef logic [NUM_PEGS*PEG_W-1:0] code_t;
    typedef logic [2:0] peg_count_t;
    typedef logic [2:0] guess_count_t;
    typedef logic [SEG_W-1:0] seg_t;
    typedef logic [3:0] hex_digit_t;

    localparam peg_index_t LAST_PEG = peg_index_t'(NUM_PEGS - 1);

    typedef struct packed {
        peg_count_t red;
        peg_count_t white;
    } score_t;

    // one write per accepted peg
    typedef struct packed {
        logic code_en;
        logic guess_en;
        peg_index_t index;
    } peg_write_t;

    typedef struct packed {
        logic start;
        logic step;
        peg_index_t index;
    } score_step_t;

    typedef enum logic [2:0] {
        CODE_SLOT,
        CODE_WAIT,
        GUESS_SLOT,
        GUESS_WAIT,
        SCORE,
        DONE
    } game_state_t;

endpackage

// ==== hdl/seven_seg_decoder.sv ====
`timescale 1ns/1ps

module seven_seg_decoder (
    input  mastermind_pkg::hex_digit_t digit_i,
    output mastermind_pkg::seg_t       segments_o
);

    // segments are low when lit
    always_comb begin
        case (digit_i)
            4'h0: segments_o = 7'b100_0000;
            4'h1: segments_o = 7'b111_1001;
            4'h2: segments_o = 7'b010_0100;
            4'h3: segments_o = 7'b011_0000;
            4'h4: segments_o = 7'b001_1001;
            4'h5: segments_o = 7'b001_0010;
            4'h6: segments_o = 7'b000_0010;
            4'h7: segments_o = 7'b111_1000;
            4'h8: segments_o = 7'b000_0000;
            4'h9: segments_o = 7'b001_1000;
            4'hA: segments_o = 7'b000_1000;
            4'hB: segments_o = 7'b000_0011;
            4'hC: segments_o = 7'b100_0110;
            4'hD: segments_o = 7'b010_0001;
            4'hE: segments_o = 7'b000_0110;
            default: segments_o = 7'b000_1110;
        endcase
    end

endmodule

// ==== hdl/game_control.sv ====
`timescale 1ns/1ps

module game_control (
    input  logic                      clock,
    input  logic                      resetn,
    input  logic                      load_i,
    output mastermind_pkg::peg_write_t  write_o,
    output mastermind_pkg::score_step_t step_o
);

    mastermind_pkg::game_state_t state_q;
    mastermind_pkg::game_state_t state_d;
    mastermind_pkg::peg_index_t index_q;
    mastermind_pkg::peg_index_t index_d;

    always_comb begin
        state_d = state_q;
        index_d = index_q;
        case (state_q)
            mastermind_pkg::CODE_SLOT: begin
                if (load_i) begin
                    state_d = mastermind_pkg::CODE_WAIT;
                end
            end
            mastermind_pkg::CODE_WAIT: begin
                // hold here until the button is let go
                if (!load_i) begin
                    if (index_q == mastermind_pkg::LAST_PEG) begin
                        state_d = mastermind_pkg::GUESS_SLOT;
                        index_d = '0;
                    end else begin
                        state_d = mastermind_pkg::CODE_SLOT;
                        index_d = index_q + 1'b1;
                    end
                end
            end
            mastermind_pkg::GUESS_SLOT: begin
                if (load_i) begin
                    state_d = mastermind_pkg::GUESS_WAIT;
                end
            end
            mastermind_pkg::GUESS_WAIT: begin
                if (!load_i) begin
                    if (index_q == mastermind_pkg::LAST_PEG) begin
                        state_d = mastermind_pkg::SCORE;
                        index_d = '0;
                    end else begin
                        state_d = mastermind_pkg::GUESS_SLOT;
                        index_d = index_q + 1'b1;
                    end
                end
            end
            mastermind_pkg::SCORE: begin
                // one code peg per cycle
                if (index_q == mastermind_pkg::LAST_PEG) begin
                    state_d = mastermind_pkg::DONE;
                    index_d = '0;
                end else begin
                    index_d = index_q + 1'b1;
                end
            end
            mastermind_pkg::DONE: begin
                // code stays, next guess starts over
                state_d = mastermind_pkg::GUESS_SLOT;
                index_d = '0;
            end
            default: begin
                state_d = mastermind_pkg::CODE_SLOT;
                index_d = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state_q <= mastermind_pkg::CODE_SLOT;
            index_q <= '0;
        end else begin
            state_q <= state_d;
            index_q <= index_d;
        end
    end

    always_comb begin
        write_o.code_en = (state_q == mastermind_pkg::CODE_SLOT) && load_i;
        write_o.guess_en = (state_q == mastermind_pkg::GUESS_SLOT) && load_i;
        write_o.index = index_q;
        // clear the scorer as the last guess peg goes in
        step_o.start = write_o.guess_en && (index_q == mastermind_pkg::LAST_PEG);
        step_o.step = (state_q == mastermind_pkg::SCORE);
        step_o.index = index_q;
    end

endmodule

// ==== hdl/peg_registers.sv ====
`timescale 1ns/1ps

module peg_registers (
    input  logic                         clock,
    input  logic                         resetn,
    input  mastermind_pkg::peg_write_t   write_i,
    input  mastermind_pkg::peg_t         data_i,
    input  logic                         done_i,
    output mastermind_pkg::code_t        code_o,
    output mastermind_pkg::code_t        guess_o,
    output mastermind_pkg::guess_count_t guess_count_o
);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_o <= '0;
            guess_o <= '0;
        end else begin
            // position 0 sits in the low bits
            if (write_i.code_en) begin
                code_o[write_i.index*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W] <= data_i;
            end
            if (write_i.guess_en) begin
                guess_o[write_i.index*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W] <= data_i;
            end
        end
    end

    // wraps at 8 on its own
    always_ff @(posedge clock) begin
        if (!resetn) begin
            guess_count_o <= '0;
        end else if (done_i) begin
            guess_count_o <= guess_count_o + 1'b1;
        end
    end

endmodule

// ==== hdl/peg_scorer.sv ====
`timescale 1ns/1ps

module peg_scorer (
    input  logic                        clock,
    input  logic                        resetn,
    input  mastermind_pkg::score_step_t step_i,
    input  mastermind_pkg::code_t       code_i,
    input  mastermind_pkg::code_t       guess_i,
    output mastermind_pkg::score_t      score_o,
    output logic                        done_o
);

    mastermind_pkg::score_t score_q;
    logic [mastermind_pkg::NUM_PEGS-1:0] used_q;
    logic [mastermind_pkg::NUM_PEGS-1:0] candidates;
    logic [mastermind_pkg::NUM_PEGS-1:0] white_mask;
    mastermind_pkg::peg_t code_peg;
    mastermind_pkg::peg_t guess_peg;
    logic exact;
    logic white_hit;

    always_comb begin
        code_peg = code_i[step_i.index*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W];
        guess_peg = guess_i[step_i.index*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W];
        exact = (code_peg == guess_peg);
        // free guess pegs of this colour that are not exact hits themselves
        for (int j = 0; j < mastermind_pkg::NUM_PEGS; j++) begin
            candidates[j] = !used_q[j]
                && (guess_i[j*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W] == code_peg)
                && (guess_i[j*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W]
                    != code_i[j*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W]);
        end
        // lowest candidate only
        white_mask = candidates & (~candidates + 1'b1);
        white_hit = |candidates;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            score_q <= '0;
            used_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= step_i.step && (step_i.index == mastermind_pkg::LAST_PEG);
            if (step_i.start) begin
                score_q <= '0;
                used_q <= '0;
            end else if (step_i.step) begin
                if (exact) begin
                    score_q.red <= score_q.red + 1'b1;
                end else if (white_hit) begin
                    score_q.white <= score_q.white + 1'b1;
                    used_q <= used_q | white_mask;
                end
            end
        end
    end

    assign score_o = score_q;

endmodule

// ==== hdl/mastermind_top.sv ====
`timescale 1ns/1ps

module mastermind_top (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic                                load_i,
    input  mastermind_pkg::peg_t                data_i,
    output mastermind_pkg::score_t              score_o,
    output logic                                result_valid_o,
    output mastermind_pkg::guess_count_t        guess_count_o,
    output logic [mastermind_pkg::HEX_DIGITS*mastermind_pkg::SEG_W-1:0] hex_o
);

    mastermind_pkg::peg_write_t write;
    mastermind_pkg::score_step_t step;
    mastermind_pkg::code_t code;
    mastermind_pkg::code_t guess;

    game_control game_control_inst (
        .clock   (clock),
        .resetn  (resetn),
        .load_i  (load_i),
        .write_o (write),
        .step_o  (step)
    );

    peg_registers peg_registers_inst (
        .clock         (clock),
        .resetn        (resetn),
        .write_i       (write),
        .data_i        (data_i),
        .done_i        (result_valid_o),
        .code_o        (code),
        .guess_o       (guess),
        .guess_count_o (guess_count_o)
    );

    peg_scorer peg_scorer_inst (
        .clock   (clock),
        .resetn  (resetn),
        .step_i  (step),
        .code_i  (code),
        .guess_i (guess),
        .score_o (score_o),
        .done_o  (result_valid_o)
    );

    // digits 0..3 are guess pegs, then red, then white
    for (genvar k = 0; k < mastermind_pkg::HEX_DIGITS; k++) begin : gen_digit
        mastermind_pkg::hex_digit_t digit;

        if (k < mastermind_pkg::NUM_PEGS) begin : gen_peg
            assign digit = {1'b0, guess[k*mastermind_pkg::PEG_W +: mastermind_pkg::PEG_W]};
        end else if (k == mastermind_pkg::NUM_PEGS) begin : gen_red
            assign digit = {1'b0, score_o.red};
        end else begin : gen_white
            assign digit = {1'b0, score_o.white};
        end

        seven_seg_decoder seven_seg_decoder_inst (
            .digit_i    (digit),
            .segments_o (hex_o[k*mastermind_pkg::SEG_W +: mastermind_pkg::SEG_W])
        );
    end

endmodule

// ==== bench/mastermind_checker.sv ====
`timescale 1ns/1ps

module mastermind_checker (
    input logic                         clock,
    input logic                         resetn,
    input mastermind_pkg::score_t       score_i,
    input logic                         result_valid_i,
    input mastermind_pkg::guess_count_t guess_count_i
);

    int unsigned failures = 0;

    score_fits: assert property (@(posedge clock) disable iff (!resetn)
        ({1'b0, score_i.red} + {1'b0, score_i.white}) <= 4'(mastermind_pkg::NUM_PEGS))
    else begin
        failures++;
        $error("red plus white is more than the number of pegs");
    end

    valid_single: assert property (@(posedge clock) disable iff (!resetn)
        result_valid_i |=> !result_valid_i)
    else begin
        failures++;
        $error("result_valid_o stayed high for more than one cycle");
    end

    valid_after_reset: assert property (@(posedge clock) !resetn |=> !result_valid_i)
    else begin
        failures++;
        $error("result_valid_o high right after reset");
    end

    // counter moves only on the edge that ends a result
    count_moves: assert property (@(posedge clock)
        (resetn && $past(resetn) && $changed(guess_count_i)) |-> $past(result_valid_i))
    else begin
        failures++;
        $error("guess_count_o changed without a result");
    end

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    input  logic restart_i,
    output logic clock_o,
    output logic resetn_o
);

    logic [1:0] hold_q;

    initial begin
        clock_o = 1'b0;
        resetn_o = 1'b0;
        hold_q = 2'd2;
    end

    // 8 ns period
    always #4 clock_o = ~clock_o;

    // reset held low for two rising edges after start or restart
    always @(posedge clock_o) begin
        if (restart_i) begin
            hold_q <= 2'd2;
            resetn_o <= 1'b0;
        end else if (hold_q != 2'd0) begin
            hold_q <= hold_q - 1'b1;
            resetn_o <= (hold_q == 2'd1);
        end
    end

endmodule

// ==== bench/mastermind_tb.sv ====
`timescale 1ns/1ps

module mastermind_tb;

    localparam int NUM_GAMES = 20;
    localparam int SHARED_CODE_GAMES = 9;
    localparam int CYCLES_PER_GAME = 60;
    localparam int TIMEOUT_CYCLES = NUM_GAMES * CYCLES_PER_GAME + 100;
    localparam logic [31:0] SEED = 32'h485cc303;

    logic clock;
    logic resetn;
    logic restart;
    logic load_i;
    mastermind_pkg::peg_t data_i;
    mastermind_pkg::score_t score_o;
    logic result_valid_o;
    mastermind_pkg::guess_count_t guess_count_o;
    logic [mastermind_pkg::HEX_DIGITS*mastermind_pkg::SEG_W-1:0] hex_o;

    logic [31:0] rand_state;
    int unsigned cycle_count;
    mastermind_pkg::code_t code;
    mastermind_pkg::code_t guess;
    mastermind_pkg::score_t expected;
    mastermind_pkg::guess_count_t expected_count;

    clock_gen clock_gen_inst (
        .restart_i (restart),
        .clock_o   (clock),
        .resetn_o  (resetn)
    );

    mastermind_top mastermind_top_inst (
        .clock          (clock),
        .resetn         (resetn),
        .load_i         (load_i),
        .data_i         (data_i),
        .score_o        (score_o),
        .result_valid_o (result_valid_o),
        .guess_count_o  (guess_count_o),
        .hex_o          (hex_o)
    );

    bind mastermind_top mastermind_checker mastermind_checker_inst (
        .clock          (clock),
        .resetn         (resetn),
        .score_i        (score_o),
        .result_valid_i (result_valid_o),
        .guess_count_i  (guess_count_o)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int unsigned random_below(input int unsigned n);
        return (next_random() >> 16) % n;
    endfunction

    // red by position, white from colour counts
    function automatic mastermind_pkg::score_t model_score(input mastermind_pkg::code_t c,
                                                           input mastermind_pkg::code_t g);
        int red;
        int common;
        int code_hits [8];
        int guess_hits [8];
        mastermind_pkg::score_t s;
        red = 0;
        common = 0;
        for (int k = 0; k < 8; k++) begin
            code_hits[k] = 0;
            guess_hits[k] = 0;
        end
        for (int i = 0; i < mastermind_pkg::NUM_PEGS; i++) begin
            if (c[i*3 +: 3] == g[i*3 +: 3]) begin
                red++;
            end
            code_hits[c[i*3 +: 3]]++;
            guess_hits[g[i*3 +: 3]]++;
        end
        for (int k = 0; k < 8; k++) begin
            common += (code_hits[k] < guess_hits[k]) ? code_hits[k] : guess_hits[k];
        end
        s.red = mastermind_pkg::peg_count_t'(red);
        s.white = mastermind_pkg::peg_count_t'(common - red);
        return s;
    endfunction

    // gfedcba lit pattern inverted for the active-low display
    function automatic mastermind_pkg::seg_t segment_pattern(input mastermind_pkg::hex_digit_t d);
        logic [6:0] lit;
        case (d)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h67;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic mastermind_pkg::code_t random_code(input bit few_colours);
        mastermind_pkg::code_t c;
        for (int i = 0; i < mastermind_pkg::NUM_PEGS; i++) begin
            c[i*3 +: 3] = few_colours ? 3'(random_below(2)) : 3'(random_below(8));
        end
        return c;
    endfunction

    // odd step mod 8 keeps all four colours apart
    function automatic mastermind_pkg::code_t distinct_code();
        mastermind_pkg::code_t c;
        int unsigned base;
        int unsigned stride;
        base = random_below(8);
        stride = 2 * random_below(4) + 1;
        for (int i = 0; i < mastermind_pkg::NUM_PEGS; i++) begin
            c[i*3 +: 3] = 3'(base + i * stride);
        end
        return c;
    endfunction

    function automatic mastermind_pkg::code_t rotate_code(input mastermind_pkg::code_t c);
        return {c[2:0], c[11:3]};
    endfunction

    task automatic check_score(input mastermind_pkg::score_t actual,
                               input mastermind_pkg::score_t want);
        if (actual !== want) begin
            stop_on_error($sformatf("error at %0t ns: score_o red %0d white %0d, expected %0d %0d",
                $time, actual.red, actual.white, want.red, want.white));
        end
    endtask

    task automatic check_count(input mastermind_pkg::guess_count_t actual,
                               input mastermind_pkg::guess_count_t want);
        if (actual !== want) begin
            stop_on_error($sformatf("error at %0t ns: guess_count_o = %0d, expected %0d",
                $time, actual, want));
        end
    endtask

    task automatic check_seg(input int digit, input mastermind_pkg::seg_t actual,
                             input mastermind_pkg::seg_t want);
        if (actual !== want) begin
            stop_on_error($sformatf("error at %0t ns: hex_o digit %0d = %b, expected %b",
                $time, digit, actual, want));
        end
    endtask

    task automatic check_display(input mastermind_pkg::code_t g, input mastermind_pkg::score_t s);
        for (int k = 0; k < mastermind_pkg::NUM_PEGS; k++) begin
            check_seg(k, hex_o[k*7 +: 7], segment_pattern({1'b0, g[k*3 +: 3]}));
        end
        check_seg(4, hex_o[28 +: 7], segment_pattern({1'b0, s.red}));
        check_seg(5, hex_o[35 +: 7], segment_pattern({1'b0, s.white}));
    endtask

    task automatic wait_reset_release();
        @(negedge clock);
        while (!resetn) @(negedge clock);
    endtask

    task automatic check_after_reset();
        if (result_valid_o !== 1'b0) begin
            stop_on_error("result_valid_o is not low after reset");
        end
        check_count(guess_count_o, '0);
        check_display('0, '0);
    endtask

    task automatic restart_game();
        @(posedge clock);
        restart <= 1'b1;
        @(posedge clock);
        restart <= 1'b0;
        wait_reset_release();
    endtask

    task automatic press_peg(input mastermind_pkg::peg_t value);
        int unsigned hold;
        int unsigned gap;
        hold = 1 + random_below(4);
        gap = 1 + random_below(4);
        @(posedge clock);
        data_i <= value;
        load_i <= 1'b1;
        repeat (hold) @(posedge clock);
        load_i <= 1'b0;
        repeat (gap - 1) @(posedge clock);
    endtask

    task automatic enter_pegs(input mastermind_pkg::code_t value);
        for (int i = 0; i < mastermind_pkg::NUM_PEGS; i++) begin
            press_peg(value[i*3 +: 3]);
        end
    endtask

    task automatic wait_result();
        @(negedge clock);
        while (result_valid_o !== 1'b1) @(negedge clock);
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error("timeout: the games did not finish within the cycle limit");
        end
    end

    always @(negedge clock) begin
        if (mastermind_top_inst.mastermind_checker_inst.failures != 0) begin
            stop_on_error("a checker assertion failed");
        end
    end

    initial begin
        load_i = 1'b0;
        data_i = '0;
        restart = 1'b0;
        cycle_count = 0;
        rand_state = SEED;
        expected_count = '0;
        wait_reset_release();
        check_after_reset();
        for (int g = 0; g < NUM_GAMES; g++) begin
            // first nine guesses share one code so the counter wraps
            if (g >= SHARED_CODE_GAMES) begin
                restart_game();
                check_after_reset();
                expected_count = '0;
            end
            if (g == 0) begin
                code = random_code(1'b0);
            end else if (g == SHARED_CODE_GAMES) begin
                code = distinct_code();
            end else if (g > SHARED_CODE_GAMES) begin
                code = random_code(g[0]);
            end
            if (g == 0 || g >= SHARED_CODE_GAMES) begin
                enter_pegs(code);
            end
            if (g == 4) begin
                guess = code;
            end else if (g == SHARED_CODE_GAMES) begin
                guess = rotate_code(code);
            end else begin
                guess = random_code(g[0] || (g % 3 == 2));
            end
            enter_pegs(guess);
            wait_result();
            // exact copy and derangement have fixed scores
            if (g == 4) begin
                expected = '{red: 3'd4, white: 3'd0};
            end else if (g == SHARED_CODE_GAMES) begin
                expected = '{red: 3'd0, white: 3'd4};
            end else begin
                expected = model_score(code, guess);
            end
            check_score(score_o, expected);
            check_display(guess, expected);
            @(negedge clock);
            expected_count = expected_count + 1'b1;
            check_count(guess_count_o, expected_count);
        end
        if (mastermind_top_inst.mastermind_checker_inst.failures == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error("a checker assertion failed");
        end
    end

endmodule

// ==== verilog.f ====
hdl/mastermind_pkg.sv
hdl/seven_seg_decoder.sv
hdl/game_control.sv
hdl/peg_registers.sv
hdl/peg_scorer.sv
hdl/mastermind_top.sv
bench/mastermind_checker.sv
bench/clock_gen.sv
bench/mastermind_tb.sv
